/* alu/alu.sv */
module alu (
  input  logic                        clk,
  input  logic                        rst_i,
  input  mips_isa_pkg::instr_fields_t instr_i,
  input  mips_ctrl_pkg::ctrl_t        ctrl_i,
  input  mips_isa_pkg::word_t         rs_i,
  input  mips_isa_pkg::word_t         rt_i,
  output mips_isa_pkg::word_t         result_o,
  output logic                        zero_o,
  output logic                        stall_o
);

  mips_isa_pkg::word_t imm_ext;
  mips_isa_pkg::word_t src_b;
  mips_isa_pkg::word_t hi_q;
  mips_isa_pkg::word_t lo_q;
  mips_isa_pkg::word_t mcand_q;
  mips_ctrl_pkg::mul_cnt_t mul_cnt;
  logic [15:0] imm;
  logic [4:0] shamt;
  logic [32:0] mul_sum;

  assign imm   = instr_i.low.immediate;
  assign shamt = instr_i.low.r.shamt;

  assign imm_ext = ctrl_i.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign src_b   = ctrl_i.src_b_imm ? imm_ext : rt_i;

  always_comb begin
    result_o = '0;
    case (instr_i.opcode)
      mips_isa_pkg::OP_SPECIAL: begin
        case (instr_i.low.r.funct)
          mips_isa_pkg::FUNC_SLL:  result_o = rt_i << shamt;
          mips_isa_pkg::FUNC_SRL:  result_o = rt_i >> shamt;
          mips_isa_pkg::FUNC_ADDU: result_o = rs_i + src_b;
          mips_isa_pkg::FUNC_SUBU: result_o = rs_i - src_b;
          mips_isa_pkg::FUNC_AND:  result_o = rs_i & src_b;
          mips_isa_pkg::FUNC_OR:   result_o = rs_i | src_b;
          mips_isa_pkg::FUNC_XOR:  result_o = rs_i ^ src_b;
          mips_isa_pkg::FUNC_SLT:  result_o = {31'd0, $signed(rs_i) < $signed(src_b)};
          mips_isa_pkg::FUNC_SLTU: result_o = {31'd0, rs_i < src_b};
          mips_isa_pkg::FUNC_MFHI: result_o = hi_q;
          mips_isa_pkg::FUNC_MFLO: result_o = lo_q;
          default:                 result_o = '0;
        endcase
      end
      // Load and store addresses come from the same adder.
      mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW: begin
        result_o = rs_i + src_b;
      end
      mips_isa_pkg::OP_ANDI: result_o = rs_i & src_b;
      mips_isa_pkg::OP_ORI:  result_o = rs_i | src_b;
      mips_isa_pkg::OP_XORI: result_o = rs_i ^ src_b;
      mips_isa_pkg::OP_LUI:  result_o = {imm, 16'h0000};
      default:               result_o = '0;
    endcase
  end

  assign zero_o = (rs_i == rt_i);

  // Shift-add step, HI accumulates while LO shifts the multiplier out.
  assign mul_sum = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mcand_q} : 33'd0);
  assign stall_o = (mul_cnt != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      hi_q    <= '0;
      lo_q    <= '0;
      mul_cnt <= '0;
    end else if (ctrl_i.mul_start) begin
      hi_q    <= '0;
      lo_q    <= rt_i;
      mul_cnt <= mips_ctrl_pkg::MULT_CNT_INIT;
    end else if (stall_o) begin
      {hi_q, lo_q} <= {mul_sum, lo_q[31:1]};
      mul_cnt      <= mul_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.mul_start) begin
      mcand_q <= rs_i;
    end
  end

  a_mul_len: assert property (@(posedge clk) disable iff (rst_i)
    $rose(stall_o) |-> ##(mips_ctrl_pkg::MULT_CYCLES) !stall_o);

endmodule

/* common/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_MEM,
    ST_WB,
    ST_HALT
  } state_t;

  typedef struct packed {
    logic pc_wen;
    logic ir_wen;
    logic reg_wen;
    logic src_b_imm;
    logic zero_ext;
    logic reg_dst_rd;
    logic wb_from_mem;
    logic mem_addr_alu;
    logic mul_start;
  } ctrl_t;

  // One multiplier bit per cycle.
  localparam int MULT_CYCLES = 32;
  localparam int MULT_CNT_W = $clog2(MULT_CYCLES) + 1;

  typedef logic [MULT_CNT_W-1:0] mul_cnt_t;

  localparam mul_cnt_t MULT_CNT_INIT = mul_cnt_t'(MULT_CYCLES);

endpackage

/* common/mips_isa_pkg.sv */
package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regaddr_t;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  typedef enum logic [5:0] {
    FUNC_SLL   = 6'h00,
    FUNC_SRL   = 6'h02,
    FUNC_JR    = 6'h08,
    FUNC_MFHI  = 6'h10,
    FUNC_MFLO  = 6'h12,
    FUNC_MULTU = 6'h19,
    FUNC_ADDU  = 6'h21,
    FUNC_SUBU  = 6'h23,
    FUNC_AND   = 6'h24,
    FUNC_OR    = 6'h25,
    FUNC_XOR   = 6'h26,
    FUNC_SLT   = 6'h2A,
    FUNC_SLTU  = 6'h2B
  } funct_t;

  // Register-format low half.
  typedef struct packed {
    regaddr_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } rtype_t;

  // The low 16 bits read either as rd/shamt/funct or as the immediate.
  typedef union packed {
    rtype_t      r;
    logic [15:0] immediate;
  } instr_low_t;

  typedef struct packed {
    opcode_t    opcode;
    regaddr_t   rs;
    regaddr_t   rt;
    instr_low_t low;
  } instr_fields_t;

  localparam word_t RESET_VECTOR = 32'hBFC0_0000;
  localparam regaddr_t REG_V0 = 5'd2;

endpackage

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mips_cpu_bus_tb \
  -f vlog.f -o sim_mips > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_mips > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"

/* source/cpu_control.sv */
module cpu_control (
  input  logic                        clk,
  input  logic                        rst_i,
  input  mips_isa_pkg::instr_fields_t instr_i,
  input  logic                        waitrequest_i,
  input  logic                        stall_i,
  input  logic                        pc_zero_i,
  output mips_ctrl_pkg::ctrl_t        ctrl_o,
  output logic                        read_o,
  output logic                        write_o,
  output mips_ctrl_pkg::state_t       state_o,
  output logic                        active_o
);

  mips_ctrl_pkg::state_t state_q;
  mips_ctrl_pkg::state_t state_d;
  mips_isa_pkg::opcode_t op;
  mips_isa_pkg::funct_t  fn;
  logic is_special;
  logic is_mem;
  logic is_branch;
  logic is_jr;
  logic is_multu;
  logic writes_reg;

  assign op = instr_i.opcode;
  assign fn = instr_i.low.r.funct;

  assign is_special = (op == mips_isa_pkg::OP_SPECIAL);
  assign is_mem     = (op == mips_isa_pkg::OP_LW) || (op == mips_isa_pkg::OP_SW);
  assign is_branch  = (op == mips_isa_pkg::OP_BEQ) || (op == mips_isa_pkg::OP_BNE);
  assign is_jr      = is_special && (fn == mips_isa_pkg::FUNC_JR);
  assign is_multu   = is_special && (fn == mips_isa_pkg::FUNC_MULTU);

  // Everything but JR, MULTU, stores and branches writes a register.
  assign writes_reg = is_special ? !(is_jr || is_multu)
                                 : !(is_branch || op == mips_isa_pkg::OP_SW);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= mips_ctrl_pkg::ST_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    ctrl_o = '0;
    // Operand and mux selects follow the instruction in every state.
    ctrl_o.src_b_imm    = !is_special && !is_branch;
    ctrl_o.zero_ext     = (op == mips_isa_pkg::OP_ANDI) || (op == mips_isa_pkg::OP_ORI) ||
                          (op == mips_isa_pkg::OP_XORI);
    ctrl_o.reg_dst_rd   = is_special;
    ctrl_o.wb_from_mem  = (op == mips_isa_pkg::OP_LW);
    ctrl_o.mem_addr_alu = (state_q == mips_ctrl_pkg::ST_MEM);
    read_o  = 1'b0;
    write_o = 1'b0;
    state_d = state_q;
    case (state_q)
      mips_ctrl_pkg::ST_FETCH: begin
        // No fetch request while reset is held.
        read_o        = !rst_i;
        ctrl_o.ir_wen = !rst_i && !waitrequest_i;
        if (!waitrequest_i) begin
          state_d = mips_ctrl_pkg::ST_DECODE;
        end
      end
      mips_ctrl_pkg::ST_DECODE: begin
        // Start here so stall is already high in the first EXEC cycle.
        ctrl_o.mul_start = is_multu;
        state_d = mips_ctrl_pkg::ST_EXEC;
      end
      mips_ctrl_pkg::ST_EXEC: begin
        if (!stall_i) begin
          state_d = is_mem ? mips_ctrl_pkg::ST_MEM : mips_ctrl_pkg::ST_WB;
        end
      end
      mips_ctrl_pkg::ST_MEM: begin
        read_o  = (op == mips_isa_pkg::OP_LW);
        write_o = (op == mips_isa_pkg::OP_SW);
        if (!waitrequest_i) begin
          state_d = mips_ctrl_pkg::ST_WB;
        end
      end
      mips_ctrl_pkg::ST_WB: begin
        ctrl_o.reg_wen = writes_reg;
        ctrl_o.pc_wen  = is_branch || is_jr;
        state_d = pc_zero_i ? mips_ctrl_pkg::ST_HALT : mips_ctrl_pkg::ST_FETCH;
      end
      mips_ctrl_pkg::ST_HALT: state_d = mips_ctrl_pkg::ST_HALT;
      default: state_d = mips_ctrl_pkg::ST_FETCH;
    endcase
  end

  assign state_o  = state_q;
  assign active_o = (state_q != mips_ctrl_pkg::ST_HALT);

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst_i) !(read_o && write_o));

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst_i)
    state_q == mips_ctrl_pkg::ST_HALT |=> state_q == mips_ctrl_pkg::ST_HALT);

endmodule

/* source/mips_cpu_bus.sv */
module mips_cpu_bus (
  input  logic                clk,
  input  logic                rst_i,
  output logic                active_o,
  output mips_isa_pkg::word_t register_v0_o,

  // Avalon-MM master.
  output mips_isa_pkg::word_t address_o,
  output logic                write_o,
  output logic                read_o,
  input  logic                waitrequest_i,
  output mips_isa_pkg::word_t writedata_o,
  output logic [3:0]          byteenable_o,
  input  mips_isa_pkg::word_t readdata_i
);

  mips_ctrl_pkg::ctrl_t        ctrl;
  mips_ctrl_pkg::state_t       state;
  mips_isa_pkg::instr_fields_t instr;
  mips_isa_pkg::word_t         pc;
  mips_isa_pkg::word_t         rs_data;
  mips_isa_pkg::word_t         rt_data;
  mips_isa_pkg::word_t         alu_result;
  mips_isa_pkg::word_t         load_q;
  mips_isa_pkg::word_t         wr_data;
  mips_isa_pkg::regaddr_t      wr_addr;
  logic alu_zero;
  logic alu_stall;
  logic pc_zero;

  // A JR to address zero in write-back ends the program.
  assign pc_zero = (state == mips_ctrl_pkg::ST_WB) &&
                   (instr.opcode == mips_isa_pkg::OP_SPECIAL) &&
                   (instr.low.r.funct == mips_isa_pkg::FUNC_JR) && (rs_data == '0);

  cpu_control u_cpu_control (
    .clk          (clk),
    .rst_i        (rst_i),
    .instr_i      (instr),
    .waitrequest_i(waitrequest_i),
    .stall_i      (alu_stall),
    .pc_zero_i    (pc_zero),
    .ctrl_o       (ctrl),
    .read_o       (read_o),
    .write_o      (write_o),
    .state_o      (state),
    .active_o     (active_o)
  );

  pc_ir u_pc_ir (
    .clk       (clk),
    .rst_i     (rst_i),
    .ctrl_i    (ctrl),
    .readdata_i(readdata_i),
    .rs_data_i (rs_data),
    .zero_i    (alu_zero),
    .pc_o      (pc),
    .instr_o   (instr)
  );

  regfile u_regfile (
    .clk      (clk),
    .rst_i    (rst_i),
    .instr_i  (instr),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .wr_en_i  (ctrl.reg_wen),
    .rs_data_o(rs_data),
    .rt_data_o(rt_data),
    .v0_o     (register_v0_o)
  );

  alu u_alu (
    .clk     (clk),
    .rst_i   (rst_i),
    .instr_i (instr),
    .ctrl_i  (ctrl),
    .rs_i    (rs_data),
    .rt_i    (rt_data),
    .result_o(alu_result),
    .zero_o  (alu_zero),
    .stall_o (alu_stall)
  );

  // Readdata is only valid in the completing MEM cycle, so hold it for WB.
  always_ff @(posedge clk) begin
    if (state == mips_ctrl_pkg::ST_MEM && !waitrequest_i) begin
      load_q <= readdata_i;
    end
  end

  assign wr_data = ctrl.wb_from_mem ? load_q : alu_result;
  assign wr_addr = ctrl.reg_dst_rd ? instr.low.r.rd : instr.rt;

  assign address_o    = ctrl.mem_addr_alu ? alu_result : pc;
  assign writedata_o  = rt_data;
  assign byteenable_o = 4'b1111;

endmodule

/* source/pc_ir.sv */
module pc_ir (
  input  logic                        clk,
  input  logic                        rst_i,
  input  mips_ctrl_pkg::ctrl_t        ctrl_i,
  input  mips_isa_pkg::word_t         readdata_i,
  input  mips_isa_pkg::word_t         rs_data_i,
  input  logic                        zero_i,
  output mips_isa_pkg::word_t         pc_o,
  output mips_isa_pkg::instr_fields_t instr_o
);

  mips_isa_pkg::word_t pc_q;
  mips_isa_pkg::word_t pc_next;
  mips_isa_pkg::instr_fields_t instr_q;
  logic [15:0] imm;
  logic is_beq;
  logic is_branch;
  logic take;

  assign imm       = instr_q.low.immediate;
  assign is_beq    = (instr_q.opcode == mips_isa_pkg::OP_BEQ);
  assign is_branch = is_beq || (instr_q.opcode == mips_isa_pkg::OP_BNE);

  // PC already points past the branch, no delay slot.
  assign pc_next = is_branch ? pc_q + {{14{imm[15]}}, imm, 2'b00} : rs_data_i;
  assign take    = !is_branch || (zero_i == is_beq);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= mips_isa_pkg::RESET_VECTOR;
    end else if (ctrl_i.ir_wen) begin
      pc_q <= pc_q + 32'd4;
    end else if (ctrl_i.pc_wen && take) begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.ir_wen) begin
      instr_q <= mips_isa_pkg::instr_fields_t'(readdata_i);
    end
  end

  assign pc_o    = pc_q;
  assign instr_o = instr_q;

endmodule

/* source/regfile.sv */
module regfile (
  input  logic                        clk,
  input  logic                        rst_i,
  input  mips_isa_pkg::instr_fields_t instr_i,
  input  mips_isa_pkg::regaddr_t      wr_addr_i,
  input  mips_isa_pkg::word_t         wr_data_i,
  input  logic                        wr_en_i,
  output mips_isa_pkg::word_t         rs_data_o,
  output mips_isa_pkg::word_t         rt_data_o,
  output mips_isa_pkg::word_t         v0_o
);

  mips_isa_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      // Register 0 is never written and stays zero.
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rs_data_o = regs[instr_i.rs];
  assign rt_data_o = regs[instr_i.rt];
  assign v0_o      = regs[mips_isa_pkg::REG_V0];

  a_wr_addr_known: assert property (@(posedge clk) disable iff (rst_i)
    wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

/* verif/avalon_ram_model.sv */
module avalon_ram_model (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                rand_wait_i,

  // Avalon-MM slave.
  input  mips_isa_pkg::word_t address_i,
  input  logic                read_i,
  input  logic                write_i,
  input  mips_isa_pkg::word_t writedata_i,
  input  logic [3:0]          byteenable_i,
  output logic                waitrequest_o,
  output mips_isa_pkg::word_t readdata_o,

  // Backdoor load and peek for the testbench.
  input  logic                load_en_i,
  input  mips_isa_pkg::word_t load_addr_i,
  input  mips_isa_pkg::word_t load_data_i,
  input  mips_isa_pkg::word_t peek_addr_i,
  output mips_isa_pkg::word_t peek_data_o,
  output logic                clash_o
);

  mips_isa_pkg::word_t mem [512];
  mips_isa_pkg::word_t fill_addr;
  mips_isa_pkg::word_t lane_mask;
  logic [1:0] wait_q;
  logic access;
  integer seed = 32'h204de830;

  // Bit 31 picks the boot window or the data window, 256 words each.
  function automatic logic [8:0] word_index(input mips_isa_pkg::word_t addr);
    return {addr[31], addr[9:2]};
  endfunction

  initial begin
    for (int i = 0; i < 512; i++) begin
      fill_addr = (i >= 256) ? mips_isa_pkg::RESET_VECTOR : '0;
      fill_addr[9:2] = 8'(i);
      mem[i] = {fill_addr[15:0], fill_addr[31:16]} ^ 32'h5A5A_A5A5;
    end
  end

  assign access        = read_i || write_i;
  assign waitrequest_o = access && (wait_q != 2'd0);
  assign readdata_o    = mem[word_index(address_i)];
  assign peek_data_o   = mem[word_index(peek_addr_i)];

  // Only the enabled byte lanes of a write reach the memory.
  assign lane_mask = {{8{byteenable_i[3]}}, {8{byteenable_i[2]}},
                      {8{byteenable_i[1]}}, {8{byteenable_i[0]}}};

  always @(posedge clk) begin
    if (load_en_i) begin
      mem[word_index(load_addr_i)] <= load_data_i;
    end else if (write_i && !waitrequest_o) begin
      mem[word_index(address_i)] <= (mem[word_index(address_i)] & ~lane_mask) |
                                    (writedata_i & lane_mask);
    end
  end

  // Wait count for the next access is drawn when the current one completes.
  always @(posedge clk) begin
    if (rst_i) begin
      wait_q  <= 2'd0;
      clash_o <= 1'b0;
    end else begin
      if (access && wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else if (access) begin
        wait_q <= rand_wait_i ? 2'($random(seed)) : 2'd0;
      end
      if (read_i && write_i) begin
        clash_o <= 1'b1;
      end
    end
  end

endmodule

/* verif/mips_cpu_bus_tb.sv */
module mips_cpu_bus_tb;

  localparam int NUM_ROWS = 8;
  localparam int CYCLE_LIMIT = NUM_ROWS * 2000;
  localparam int HALT_WATCH = 20;
  localparam mips_isa_pkg::word_t DATA_ADDR = 32'h0000_0100;
  localparam mips_isa_pkg::word_t DATA_INIT = 32'h0BAD_F00D;
  localparam mips_isa_pkg::word_t STORE_WORD = 32'hA5C3_1E7F;
  localparam mips_isa_pkg::word_t MUL_A = 32'hDEAD_BEEF;
  localparam mips_isa_pkg::word_t MUL_B = 32'h1234_5678;
  localparam mips_isa_pkg::word_t LOOP_N = 32'd5;
  localparam logic [1:0] PROG_ALU = 2'd0;
  localparam logic [1:0] PROG_MEM = 2'd1;
  localparam logic [1:0] PROG_MUL = 2'd2;
  localparam logic [1:0] PROG_BRANCH = 2'd3;

  localparam mips_isa_pkg::regaddr_t R0 = 5'd0;
  localparam mips_isa_pkg::regaddr_t V0 = mips_isa_pkg::REG_V0;
  localparam mips_isa_pkg::regaddr_t T0 = 5'd8;
  localparam mips_isa_pkg::regaddr_t T1 = 5'd9;
  localparam mips_isa_pkg::regaddr_t T2 = 5'd10;
  localparam mips_isa_pkg::regaddr_t T3 = 5'd11;
  localparam mips_isa_pkg::regaddr_t T4 = 5'd12;
  localparam mips_isa_pkg::regaddr_t T5 = 5'd13;
  localparam mips_isa_pkg::regaddr_t T6 = 5'd14;
  localparam mips_isa_pkg::regaddr_t T7 = 5'd15;
  localparam mips_isa_pkg::regaddr_t T8 = 5'd24;
  localparam mips_isa_pkg::regaddr_t T9 = 5'd25;
  localparam mips_isa_pkg::regaddr_t S0 = 5'd16;
  localparam mips_isa_pkg::regaddr_t S1 = 5'd17;
  localparam mips_isa_pkg::regaddr_t S2 = 5'd18;
  localparam mips_isa_pkg::regaddr_t S3 = 5'd19;

  typedef struct packed {
    logic [1:0]          prog_id;
    logic                rand_wait;
    mips_isa_pkg::word_t exp_v0;
    mips_isa_pkg::word_t exp_mem;
  } test_row_t;

  logic clk;
  logic rst_i;
  logic active;
  logic read;
  logic write;
  logic waitrequest;
  logic rand_wait;
  logic load_en;
  logic clash;
  logic [3:0] byteenable;
  mips_isa_pkg::word_t v0;
  mips_isa_pkg::word_t address;
  mips_isa_pkg::word_t writedata;
  mips_isa_pkg::word_t readdata;
  mips_isa_pkg::word_t load_addr;
  mips_isa_pkg::word_t load_data;
  mips_isa_pkg::word_t peek_data;
  mips_isa_pkg::word_t prog [$];
  test_row_t rows [NUM_ROWS];
  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;

  mips_cpu_bus u_mips_cpu_bus (
    .clk          (clk),
    .rst_i        (rst_i),
    .active_o     (active),
    .register_v0_o(v0),
    .address_o    (address),
    .write_o      (write),
    .read_o       (read),
    .waitrequest_i(waitrequest),
    .writedata_o  (writedata),
    .byteenable_o (byteenable),
    .readdata_i   (readdata)
  );

  avalon_ram_model u_ram (
    .clk          (clk),
    .rst_i        (rst_i),
    .rand_wait_i  (rand_wait),
    .address_i    (address),
    .read_i       (read),
    .write_i      (write),
    .writedata_i  (writedata),
    .byteenable_i (byteenable),
    .waitrequest_o(waitrequest),
    .readdata_o   (readdata),
    .load_en_i    (load_en),
    .load_addr_i  (load_addr),
    .load_data_i  (load_data),
    .peek_addr_i  (DATA_ADDR),
    .peek_data_o  (peek_data),
    .clash_o      (clash)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles: the processor never halted", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic mips_isa_pkg::word_t enc_r(input mips_isa_pkg::funct_t fn,
      input mips_isa_pkg::regaddr_t rs, input mips_isa_pkg::regaddr_t rt,
      input mips_isa_pkg::regaddr_t rd, input logic [4:0] sh);
    return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  function automatic mips_isa_pkg::word_t enc_i(input mips_isa_pkg::opcode_t op,
      input mips_isa_pkg::regaddr_t rs, input mips_isa_pkg::regaddr_t rt,
      input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Mirrors the ALU program below step by step from the instruction definitions.
  function automatic mips_isa_pkg::word_t expect_alu();
    mips_isa_pkg::word_t t0;
    mips_isa_pkg::word_t t1;
    mips_isa_pkg::word_t t6;
    mips_isa_pkg::word_t t7;
    mips_isa_pkg::word_t t9;
    mips_isa_pkg::word_t s2;
    mips_isa_pkg::word_t s3;
    t0 = 32'h0000_1234;
    t1 = 32'h8000_0000 | 32'h0000_00F0;
    t6 = ((t0 + t1) & (t0 - t1)) ^ ((t0 + t1) | (t0 - t1));
    t7 = ($signed(t0) < $signed(t1)) ? 32'd1 : 32'd0;
    t9 = ((t0 < t1) ? 32'd1 : 32'd0) << 5;
    s2 = (t6 & 32'h0000_FF0F) ^ 32'h0000_FFFF;
    s3 = (t9 ^ t7) + (t1 >> 8);
    return s2 + s3;
  endfunction

  function automatic mips_isa_pkg::word_t expect_mul(input mips_isa_pkg::word_t a,
      input mips_isa_pkg::word_t b);
    logic [63:0] product;
    product = {32'd0, a} * {32'd0, b};
    return product[63:32] ^ product[31:0];
  endfunction

  function automatic string prog_name(input logic [1:0] id);
    case (id)
      PROG_ALU: return "alu";
      PROG_MEM: return "memory";
      PROG_MUL: return "multiply";
      default:  return "branch";
    endcase
  endfunction

  task automatic build_program(input logic [1:0] id);
    prog.delete();
    case (id)
      PROG_ALU: begin
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, R0, T0, 16'h1234));
        prog.push_back(enc_i(mips_isa_pkg::OP_LUI, R0, T1, 16'h8000));
        prog.push_back(enc_i(mips_isa_pkg::OP_ORI, T1, T1, 16'h00F0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_ADDU, T0, T1, T2, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_SUBU, T0, T1, T3, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_AND, T2, T3, T4, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_OR, T2, T3, T5, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_XOR, T4, T5, T6, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_SLT, T0, T1, T7, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_SLTU, T0, T1, T8, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_SLL, R0, T8, T9, 5'd5));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_SRL, R0, T1, S0, 5'd8));
        prog.push_back(enc_i(mips_isa_pkg::OP_ANDI, T6, S1, 16'hFF0F));
        prog.push_back(enc_i(mips_isa_pkg::OP_XORI, S1, S2, 16'hFFFF));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_XOR, T9, T7, S3, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_ADDU, S3, S0, S3, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_ADDU, S2, S3, V0, 5'd0));
      end
      PROG_MEM: begin
        prog.push_back(enc_i(mips_isa_pkg::OP_LUI, R0, T0, STORE_WORD[31:16]));
        prog.push_back(enc_i(mips_isa_pkg::OP_ORI, T0, T0, STORE_WORD[15:0]));
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, R0, T1, DATA_ADDR[15:0] - 16'h10));
        prog.push_back(enc_i(mips_isa_pkg::OP_SW, T1, T0, 16'h0010));
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, R0, T2, DATA_ADDR[15:0] + 16'h4));
        prog.push_back(enc_i(mips_isa_pkg::OP_LW, T2, V0, 16'hFFFC));
      end
      PROG_MUL: begin
        prog.push_back(enc_i(mips_isa_pkg::OP_LUI, R0, T0, MUL_A[31:16]));
        prog.push_back(enc_i(mips_isa_pkg::OP_ORI, T0, T0, MUL_A[15:0]));
        prog.push_back(enc_i(mips_isa_pkg::OP_LUI, R0, T1, MUL_B[31:16]));
        prog.push_back(enc_i(mips_isa_pkg::OP_ORI, T1, T1, MUL_B[15:0]));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_MULTU, T0, T1, R0, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_MFHI, R0, R0, T2, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_MFLO, R0, R0, T3, 5'd0));
        prog.push_back(enc_r(mips_isa_pkg::FUNC_XOR, T2, T3, V0, 5'd0));
      end
      default: begin
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, R0, T0, LOOP_N[15:0]));
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, R0, V0, 16'h0000));
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, V0, V0, 16'h0001));
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, T0, T0, 16'hFFFF));
        // Back to the increment, three words before the next PC.
        prog.push_back(enc_i(mips_isa_pkg::OP_BNE, T0, R0, 16'hFFFD));
        prog.push_back(enc_i(mips_isa_pkg::OP_BEQ, R0, R0, 16'h0001));
        prog.push_back(enc_i(mips_isa_pkg::OP_ADDIU, V0, V0, 16'h0100));
      end
    endcase
    prog.push_back(enc_r(mips_isa_pkg::FUNC_JR, R0, R0, R0, 5'd0));
  endtask

  // Program goes in at the reset vector, then the data word gets its start value.
  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= mips_isa_pkg::RESET_VECTOR + mips_isa_pkg::word_t'(4 * i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_addr <= DATA_ADDR;
    load_data <= DATA_INIT;
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_i <= 1'b1;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
  endtask

  task automatic wait_for_halt();
    @(negedge clk);
    while (active) begin
      @(negedge clk);
    end
  endtask

  task automatic check_word(input string what, input mips_isa_pkg::word_t got,
      input mips_isa_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_mem(input mips_isa_pkg::word_t exp);
    if (peek_data !== exp) begin
      $display("Mismatch at time %0t: memory at %h is %h, expected %h",
               $time, DATA_ADDR, peek_data, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_after_halt();
    mips_isa_pkg::word_t v0_held;
    logic quiet;
    v0_held = v0;
    quiet = 1'b1;
    repeat (HALT_WATCH) begin
      @(negedge clk);
      if (active || read || write) begin
        quiet = 1'b0;
      end
    end
    check_flag("bus quiet after halt", quiet, 1'b1);
    check_word("v0 held after halt", v0, v0_held);
  endtask

  initial begin
    test_row_t row;
    int err_before;
    rst_i     = 1'b1;
    rand_wait = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    rows[0] = '{prog_id: PROG_ALU, rand_wait: 1'b0, exp_v0: expect_alu(), exp_mem: DATA_INIT};
    rows[1] = '{prog_id: PROG_MEM, rand_wait: 1'b0, exp_v0: STORE_WORD, exp_mem: STORE_WORD};
    rows[2] = '{prog_id: PROG_MUL, rand_wait: 1'b0, exp_v0: expect_mul(MUL_A, MUL_B),
                exp_mem: DATA_INIT};
    rows[3] = '{prog_id: PROG_BRANCH, rand_wait: 1'b0, exp_v0: LOOP_N, exp_mem: DATA_INIT};
    // Same programs again with random wait states.
    for (int i = 0; i < 4; i++) begin
      rows[i + 4] = rows[i];
      rows[i + 4].rand_wait = 1'b1;
    end

    for (int t = 0; t < NUM_ROWS; t++) begin
      row = rows[t];
      err_before = error_count;
      build_program(row.prog_id);
      @(posedge clk);
      rand_wait <= row.rand_wait;
      load_program();
      reset_dut();
      wait_for_halt();
      check_word("register_v0", v0, row.exp_v0);
      check_mem(row.exp_mem);
      check_after_halt();
      check_flag("read and write together", clash, 1'b0);
      if (error_count == err_before) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("Test %0d %s, %s wait states: %s", t, prog_name(row.prog_id),
               row.rand_wait ? "random" : "no", (error_count == err_before) ? "ok" : "errors");
    end

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
source/cpu_control.sv
source/pc_ir.sv
source/regfile.sv
alu/alu.sv
source/mips_cpu_bus.sv
verif/avalon_ram_model.sv
verif/mips_cpu_bus_tb.sv
